//--- common/mcu_pkg.sv
`default_nettype none

package mcu_pkg;

  localparam int ADDR_WIDTH = 10;
  localparam int DATA_W     = 16;
  localparam int PWORD_W    = 18;  // program word width

  localparam int PMEM_WORDS = 256;
  localparam int PMEM_AW    = $clog2(PMEM_WORDS);
  localparam int DMEM_BYTES = 512;
  localparam int DMEM_AW    = $clog2(DMEM_BYTES);

  localparam logic [ADDR_WIDTH-1:0] DMEM_GVAR_START = 10'h100;
  localparam logic [ADDR_WIDTH-1:0] IO_LIMIT        = 10'h040;  // below: registers

  // register map
  localparam logic [ADDR_WIDTH-1:0] REG_TIMER_CNT = 10'h002;
  localparam logic [ADDR_WIDTH-1:0] REG_TIMER_CTL = 10'h004;
  localparam logic [ADDR_WIDTH-1:0] REG_UART_DATA = 10'h006;
  localparam logic [ADDR_WIDTH-1:0] REG_UART_CTL  = 10'h008;

  typedef enum logic [2:0] {
    SEL_TIMER_CNT,
    SEL_TIMER_CTL,
    SEL_UART_DATA,
    SEL_UART_CTL,
    SEL_NONE
  } io_sel_t;

endpackage

`default_nettype wire

//--- common/loader_pkg.sv
`default_nettype none

package loader_pkg;

  // uart bit timing
  localparam int CLKS_PER_BIT = 8;
  localparam int CLK_CNT_W    = $clog2(CLKS_PER_BIT);

  // image sync pair
  localparam logic [7:0] SYNC_HI = 8'h55;
  localparam logic [7:0] SYNC_LO = 8'hAA;

  localparam int TIMER_TICK = 4;  // clocks per timer decrement
  localparam int TICK_W     = $clog2(TIMER_TICK);

  typedef enum logic [2:0] {
    WAIT,  // hunting for 55 AA
    META,  // two size words
    PMEM,
    DMEM,
    FIN
  } load_state_t;

endpackage

`default_nettype wire

//--- common/mem_bus_if.sv
`timescale 1ns/1ns
`default_nettype none

interface mem_bus_if import mcu_pkg::*; ();

  logic [ADDR_WIDTH-1:0] addr;   // byte address
  logic                  wen;
  logic                  ren;
  logic [DATA_W-1:0]     wdata;
  logic [DATA_W-1:0]     rdata;  // one cycle after ren

  modport master (
    output addr,
    output wen,
    output ren,
    output wdata,
    input  rdata
  );

  modport slave (
    input  addr,
    input  wen,
    input  ren,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

//--- uart/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx import loader_pkg::*; (
  input  logic       rst,
  input  logic       clk,
  input  logic       rxd,
  output logic [7:0] rx_byte,
  output logic       rx_strobe
);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  rx_state_t            state;
  logic                 rx_meta;
  logic                 rx_sync;
  logic [CLK_CNT_W-1:0] clk_cnt;
  logic [2:0]           bit_cnt;
  logic [7:0]           shreg;
  logic                 bit_end;
  logic                 mid_start;

  assign bit_end   = clk_cnt == CLK_CNT_W'(CLKS_PER_BIT - 1);
  assign mid_start = clk_cnt == CLK_CNT_W'(CLKS_PER_BIT / 2 - 1);

  // line idles high
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rxd;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      state     <= RX_IDLE;
      clk_cnt   <= '0;
      bit_cnt   <= '0;
      rx_strobe <= 1'b0;
    end else begin
      rx_strobe <= 1'b0;
      case (state)
        RX_IDLE: begin
          clk_cnt <= '0;
          if (!rx_sync)
            state <= RX_START;
        end
        RX_START: begin
          if (mid_start) begin
            clk_cnt <= '0;
            bit_cnt <= '0;
            state   <= rx_sync ? RX_IDLE : RX_DATA;  // glitch, not a start bit
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            clk_cnt <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7)
              state <= RX_STOP;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (bit_end) begin
            rx_strobe <= rx_sync;  // framing error drops the byte
            state     <= RX_IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // lsb first
  always_ff @(posedge rst) begin
    if (state == RX_DATA && bit_end)
      shreg <= {rx_sync, shreg[7:1]};
    if (state == RX_STOP && bit_end)
      rx_byte <= shreg;
  end

endmodule

`default_nettype wire

//--- loader/img_loader.sv
`timescale 1ns/1ns
`default_nettype none

module img_loader import mcu_pkg::*, loader_pkg::*; (
  input  logic                  rst,
  input  logic                  clk,
  input  logic [7:0]            rx_byte,
  input  logic                  rx_strobe,
  output logic                  loading,
  output logic                  pmem_wen,
  output logic [ADDR_WIDTH-1:0] pmem_waddr,
  output logic [PWORD_W-1:0]    pmem_wdata,
  mem_bus_if.master             dbus
);

  load_state_t           state;
  logic [PWORD_W-1:0]    shreg;       // last 18 received bits
  logic [1:0]            phase;
  logic [1:0]            last_phase;
  logic                  word_done;
  logic                  sync_seen;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [ADDR_WIDTH-1:0] pmem_size;
  logic [ADDR_WIDTH-1:0] dmem_size;   // in words
  logic [ADDR_WIDTH-1:0] dmem_end;

  assign sync_seen  = rx_strobe && shreg[7:0] == SYNC_HI && rx_byte == SYNC_LO;
  assign last_phase = (state == PMEM) ? 2'd2 : 2'd1;
  assign dmem_end   = DMEM_GVAR_START + {dmem_size[ADDR_WIDTH-2:0], 1'b0};

  always_ff @(posedge rst or posedge clk) begin
    if (clk)
      shreg <= '0;
    else if (rx_strobe)
      shreg <= {shreg[PWORD_W-9:0], rx_byte};
  end

  // byte position within the current word
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      phase     <= '0;
      word_done <= 1'b0;
    end else begin
      word_done <= 1'b0;
      if (state == WAIT || state == FIN) begin
        phase <= '0;
      end else if (rx_strobe) begin
        if (phase == last_phase) begin
          phase     <= '0;
          word_done <= 1'b1;
        end else begin
          phase <= phase + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      state     <= WAIT;
      wr_addr   <= '0;
      pmem_size <= '0;
      dmem_size <= '0;
    end else begin
      case (state)
        WAIT: begin
          if (sync_seen) begin
            state   <= META;
            wr_addr <= '0;
          end
        end
        META: begin
          // wr_addr doubles as the metadata word index
          if (word_done) begin
            if (wr_addr == '0) begin
              pmem_size <= shreg[ADDR_WIDTH-1:0];
              wr_addr   <= ADDR_WIDTH'(1);
            end else begin
              dmem_size <= shreg[ADDR_WIDTH-1:0];
              wr_addr   <= '0;
              state     <= PMEM;
            end
          end
        end
        PMEM: begin
          if (wr_addr == pmem_size) begin  // also covers size 0
            state   <= DMEM;
            wr_addr <= DMEM_GVAR_START;
          end else if (word_done) begin
            wr_addr <= wr_addr + 1'b1;
          end
        end
        DMEM: begin
          if (wr_addr == dmem_end)
            state <= FIN;
          else if (word_done)
            wr_addr <= wr_addr + ADDR_WIDTH'(2);
        end
        FIN:     state <= WAIT;
        default: state <= WAIT;
      endcase
    end
  end

  assign loading    = state != WAIT;

  assign pmem_wen   = word_done && state == PMEM;
  assign pmem_waddr = wr_addr;
  assign pmem_wdata = shreg;

  assign dbus.addr  = wr_addr;
  assign dbus.wen   = word_done && state == DMEM;
  assign dbus.ren   = 1'b0;  // write only
  assign dbus.wdata = shreg[DATA_W-1:0];

endmodule

`default_nettype wire

//--- source/pmem.sv
`timescale 1ns/1ns
`default_nettype none

module pmem import mcu_pkg::*; (
  input  logic                  rst,
  input  logic                  clk,
  input  logic                  wen,
  input  logic [ADDR_WIDTH-1:0] waddr,
  input  logic [PWORD_W-1:0]    wdata,
  input  logic [ADDR_WIDTH-1:0] raddr,
  output logic [PWORD_W-1:0]    rdata
);

  logic [PWORD_W-1:0] mem [PMEM_WORDS];

  always_ff @(posedge rst) begin
    if (wen)
      mem[waddr[PMEM_AW-1:0]] <= wdata;
  end

  // fetch port, one cycle latency
  always_ff @(posedge rst or posedge clk) begin
    if (clk)
      rdata <= '0;
    else
      rdata <= mem[raddr[PMEM_AW-1:0]];
  end

endmodule

`default_nettype wire

//--- source/dmem.sv
`timescale 1ns/1ns
`default_nettype none

module dmem import mcu_pkg::*; (
  input  logic      rst,
  input  logic      clk,
  mem_bus_if.slave  bus
);

  logic [DATA_W-1:0]  mem [DMEM_BYTES / 2];
  logic [DMEM_AW-2:0] widx;  // word index, bit 0 ignored

  assign widx = bus.addr[DMEM_AW-1:1];

  always_ff @(posedge rst) begin
    if (bus.wen)
      mem[widx] <= bus.wdata;
  end

  // held while ren is low
  always_ff @(posedge rst or posedge clk) begin
    if (clk)
      bus.rdata <= '0;
    else if (bus.ren)
      bus.rdata <= mem[widx];
  end

endmodule

`default_nettype wire

//--- source/io_regs.sv
`timescale 1ns/1ns
`default_nettype none

module io_regs import mcu_pkg::*, loader_pkg::*; (
  input  logic       rst,
  input  logic       clk,
  input  logic [7:0] rx_byte,
  input  logic       rx_strobe,
  mem_bus_if.slave   bus,
  output logic       irq
);

  io_sel_t           sel;
  logic [DATA_W-1:0] timer_cnt;
  logic [TICK_W-1:0] tick_cnt;
  logic              tick_wrap;
  logic              timer_done;
  logic              timeout;
  logic              timer_ie;
  logic [7:0]        uart_data;
  logic              rx_ready;
  logic              uart_ie;

  always_comb begin
    case (bus.addr)
      REG_TIMER_CNT: sel = SEL_TIMER_CNT;
      REG_TIMER_CTL: sel = SEL_TIMER_CTL;
      REG_UART_DATA: sel = SEL_UART_DATA;
      REG_UART_CTL:  sel = SEL_UART_CTL;
      default:       sel = SEL_NONE;
    endcase
  end

  assign tick_wrap  = tick_cnt == TICK_W'(TIMER_TICK - 1);
  assign timer_done = tick_wrap && timer_cnt == DATA_W'(1);  // last decrement

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      timer_cnt <= '0;
      tick_cnt  <= '0;
    end else if (bus.wen && sel == SEL_TIMER_CNT) begin
      timer_cnt <= bus.wdata;
      tick_cnt  <= '0;
    end else if (timer_cnt != '0) begin
      tick_cnt <= tick_wrap ? '0 : tick_cnt + 1'b1;
      if (tick_wrap)
        timer_cnt <= timer_cnt - 1'b1;
    end
  end

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      timeout  <= 1'b0;
      timer_ie <= 1'b0;
    end else if (bus.wen && sel == SEL_TIMER_CTL) begin
      timer_ie <= bus.wdata[1];
      timeout  <= 1'b0;  // write acknowledges
    end else if (timer_done) begin
      timeout <= 1'b1;
    end
  end

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      rx_ready <= 1'b0;
      uart_ie  <= 1'b0;
    end else begin
      if (bus.wen && sel == SEL_UART_CTL)
        uart_ie <= bus.wdata[1];
      if (rx_strobe)
        rx_ready <= 1'b1;  // new byte wins over a read
      else if (bus.ren && sel == SEL_UART_DATA)
        rx_ready <= 1'b0;
    end
  end

  always_ff @(posedge rst) begin
    if (rx_strobe)
      uart_data <= rx_byte;
  end

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      bus.rdata <= '0;
    end else if (bus.ren) begin
      case (sel)
        SEL_TIMER_CNT: bus.rdata <= timer_cnt;
        SEL_TIMER_CTL: bus.rdata <= {14'd0, timer_ie, timeout};
        SEL_UART_DATA: bus.rdata <= {8'd0, uart_data};
        SEL_UART_CTL:  bus.rdata <= {14'd0, uart_ie, rx_ready};
        default:       bus.rdata <= '0;
      endcase
    end
  end

  assign irq = (timeout & timer_ie) | (rx_ready & uart_ie);

endmodule

`default_nettype wire

//--- source/mcu_boot.sv
`timescale 1ns/1ns
`default_nettype none

module mcu_boot import mcu_pkg::*; (
  input  logic                  rst,
  input  logic                  clk,
  input  logic                  uart_rx,
  input  logic [ADDR_WIDTH-1:0] bus_addr,
  input  logic                  bus_wen,
  input  logic                  bus_ren,
  input  logic [DATA_W-1:0]     bus_wdata,
  output logic [DATA_W-1:0]     bus_rdata,
  input  logic [ADDR_WIDTH-1:0] fetch_addr,
  output logic [PWORD_W-1:0]    fetch_data,
  output logic                  run,
  output logic                  irq
);

  mem_bus_if loader_bus ();
  mem_bus_if host_bus ();
  mem_bus_if io_bus ();
  mem_bus_if dm_bus ();

  logic [7:0]            rx_byte;
  logic                  rx_strobe;
  logic                  loading;
  logic                  pmem_wen;
  logic [ADDR_WIDTH-1:0] pmem_waddr;
  logic [PWORD_W-1:0]    pmem_wdata;
  logic [ADDR_WIDTH-1:0] req_addr;
  logic                  req_wen;
  logic                  req_ren;
  logic [DATA_W-1:0]     req_wdata;
  logic                  req_io;
  logic                  rd_io_q;
  logic                  rd_host_q;
  logic [DATA_W-1:0]     rd_data;

  assign host_bus.addr  = bus_addr;
  assign host_bus.wen   = bus_wen;
  assign host_bus.ren   = bus_ren;
  assign host_bus.wdata = bus_wdata;
  assign bus_rdata      = host_bus.rdata;

  // loader owns the bus while loading, host is ignored
  assign req_addr  = loading ? loader_bus.addr  : host_bus.addr;
  assign req_wen   = loading ? loader_bus.wen   : host_bus.wen;
  assign req_ren   = loading ? loader_bus.ren   : host_bus.ren;
  assign req_wdata = loading ? loader_bus.wdata : host_bus.wdata;
  assign req_io    = req_addr < IO_LIMIT;

  assign io_bus.addr  = req_addr;
  assign io_bus.wen   = req_wen & req_io;
  assign io_bus.ren   = req_ren & req_io;
  assign io_bus.wdata = req_wdata;

  assign dm_bus.addr  = req_addr;
  assign dm_bus.wen   = req_wen & ~req_io;
  assign dm_bus.ren   = req_ren & ~req_io;
  assign dm_bus.wdata = req_wdata;

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      rd_io_q   <= 1'b0;
      rd_host_q <= 1'b0;
    end else begin
      if (req_ren)
        rd_io_q <= req_io;
      if (host_bus.ren)
        rd_host_q <= ~loading;  // read during load returns 0
    end
  end

  assign rd_data          = rd_io_q ? io_bus.rdata : dm_bus.rdata;
  assign loader_bus.rdata = rd_data;
  assign host_bus.rdata   = rd_host_q ? rd_data : '0;

  assign run = ~loading;

  uart_rx i_uart_rx (
    .rst       (rst),
    .clk       (clk),
    .rxd       (uart_rx),
    .rx_byte   (rx_byte),
    .rx_strobe (rx_strobe)
  );

  img_loader i_img_loader (
    .rst        (rst),
    .clk        (clk),
    .rx_byte    (rx_byte),
    .rx_strobe  (rx_strobe),
    .loading    (loading),
    .pmem_wen   (pmem_wen),
    .pmem_waddr (pmem_waddr),
    .pmem_wdata (pmem_wdata),
    .dbus       (loader_bus)
  );

  pmem i_pmem (
    .rst   (rst),
    .clk   (clk),
    .wen   (pmem_wen),
    .waddr (pmem_waddr),
    .wdata (pmem_wdata),
    .raddr (fetch_addr),
    .rdata (fetch_data)
  );

  dmem i_dmem (
    .rst (rst),
    .clk (clk),
    .bus (dm_bus)
  );

  // image bytes stay out of the uart registers
  io_regs i_io_regs (
    .rst       (rst),
    .clk       (clk),
    .rx_byte   (rx_byte),
    .rx_strobe (rx_strobe & run),
    .bus       (io_bus),
    .irq       (irq)
  );

endmodule

`default_nettype wire

//--- bench/mcu_boot_checker.sv
`timescale 1ns/1ns
`default_nettype none

module mcu_boot_checker import mcu_pkg::*, loader_pkg::*; (
  input logic                  rst,
  input logic                  clk,
  input load_state_t           state,
  input logic                  pmem_wen,
  input logic                  dbus_wen,
  input logic [ADDR_WIDTH-1:0] pmem_waddr,
  input logic [ADDR_WIDTH-1:0] pmem_size,
  input logic [ADDR_WIDTH-1:0] dmem_size
);

  // one memory written per completed word
  one_writer: assert property (@(posedge rst) disable iff (clk)
    (pmem_wen || dbus_wen) |-> !(pmem_wen && dbus_wen) && !$past(pmem_wen || dbus_wen))
    else $error("program and data memory written in the same or back-to-back cycles");

  pmem_in_range: assert property (@(posedge rst) disable iff (clk)
    pmem_wen |-> pmem_waddr < pmem_size)
    else $error("program word written beyond the image size");

  // fin comes two cycles after the last data word
  fin_one_cycle: assert property (@(posedge rst) disable iff (clk)
    state == FIN |-> $past(state) != FIN && (dmem_size == '0 || $past(dbus_wen, 2)))
    else $error("loader FIN state too long or not right after the last data word");

endmodule

bind img_loader mcu_boot_checker i_checker (
  .rst        (rst),
  .clk        (clk),
  .state      (state),
  .pmem_wen   (pmem_wen),
  .dbus_wen   (dbus.wen),
  .pmem_waddr (pmem_waddr),
  .pmem_size  (pmem_size),
  .dmem_size  (dmem_size)
);

`default_nettype wire

//--- bench/tb_mcu_boot.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mcu_boot import mcu_pkg::*, loader_pkg::*; ();

  localparam string TEST_FILE      = "bench/boot_tests.txt";
  localparam int    MAX_LINE_BYTES = 16;
  localparam int    WORST_CMD_CYC  = MAX_LINE_BYTES * 10 * CLKS_PER_BIT + 16;

  logic                  rst;  // clock
  logic                  clk;  // reset, active high
  logic                  uart_rx;
  logic [ADDR_WIDTH-1:0] bus_addr;
  logic                  bus_wen;
  logic                  bus_ren;
  logic [DATA_W-1:0]     bus_wdata;
  logic [DATA_W-1:0]     bus_rdata;
  logic [ADDR_WIDTH-1:0] fetch_addr;
  logic [PWORD_W-1:0]    fetch_data;
  logic                  run;
  logic                  irq;

  int          n_checks;
  int          n_errors;
  int          limit_cycles;
  logic [31:0] lcg_state;
  logic [31:0] fields [$];

  mcu_boot i_mcu_boot (
    .rst        (rst),
    .clk        (clk),
    .uart_rx    (uart_rx),
    .bus_addr   (bus_addr),
    .bus_wen    (bus_wen),
    .bus_ren    (bus_ren),
    .bus_wdata  (bus_wdata),
    .bus_rdata  (bus_rdata),
    .fetch_addr (fetch_addr),
    .fetch_data (fetch_data),
    .run        (run),
    .irq        (irq)
  );

  initial begin
    rst = 1'b0;
    forever #2 rst = ~rst;
  end

  function automatic logic [7:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  function automatic logic is_hex(input logic [7:0] c);
    return (c >= "0" && c <= "9") || (c >= "a" && c <= "f") || (c >= "A" && c <= "F");
  endfunction

  function automatic logic [3:0] hex_value(input logic [7:0] c);
    if (c >= "0" && c <= "9")
      return 4'(c - 8'h30);
    else if (c >= "a" && c <= "f")
      return 4'(c - 8'h57);
    else
      return 4'(c - 8'h37);
  endfunction

  // hex fields after the command letter
  task automatic parse_fields(input string line);
    logic [31:0] val;
    logic [7:0]  c;
    logic        in_tok;
    fields.delete();
    val    = '0;
    in_tok = 1'b0;
    for (int i = 1; i < line.len(); i++) begin
      c = line[i];
      if (is_hex(c)) begin
        val    = {val[27:0], hex_value(c)};
        in_tok = 1'b1;
      end else if (in_tok) begin
        fields.push_back(val);
        val    = '0;
        in_tok = 1'b0;
      end
    end
    if (in_tok)
      fields.push_back(val);
  endtask

  // 8N1, lsb first
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge rst);
      #1 uart_rx = frame[i];
      repeat (CLKS_PER_BIT - 1) @(posedge rst);
    end
  endtask

  task automatic send_noise(input int count);
    logic [7:0] b;
    repeat (count) begin
      do
        b = next_rand();
      while (b == SYNC_HI);
      send_byte(b);
    end
  endtask

  task automatic write_word(input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_W-1:0] data);
    @(posedge rst);
    #1;
    bus_addr  = addr;
    bus_wdata = data;
    bus_wen   = 1'b1;
    @(posedge rst);
    #1 bus_wen = 1'b0;
  endtask

  task automatic read_check(input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_W-1:0] exp);
    @(posedge rst);
    #1;
    bus_addr = addr;
    bus_ren  = 1'b1;
    @(posedge rst);
    #1 bus_ren = 1'b0;
    n_checks++;
    assert (bus_rdata === exp) else begin
      n_errors++;
      $display("ERROR bus_rdata at 0x%h: got 0x%h, expected 0x%h", addr, bus_rdata, exp);
    end
  endtask

  task automatic fetch_check(input logic [ADDR_WIDTH-1:0] addr, input logic [PWORD_W-1:0] exp);
    @(posedge rst);
    #1 fetch_addr = addr;
    @(posedge rst);
    #1;
    n_checks++;
    assert (fetch_data === exp) else begin
      n_errors++;
      $display("ERROR fetch_data at 0x%h: got 0x%h, expected 0x%h", addr, fetch_data, exp);
    end
  endtask

  // S checks run, I checks irq
  task automatic level_check(input logic [7:0] cmd, input logic exp);
    logic  actual;
    string name;
    @(posedge rst);
    #1;
    actual = (cmd == "S") ? run : irq;
    name   = (cmd == "S") ? "run" : "irq";
    n_checks++;
    assert (actual === exp) else begin
      n_errors++;
      $display("ERROR %s: got 0x%h, expected 0x%h", name, actual, exp);
    end
  endtask

  task automatic run_line(input string line);
    logic [7:0] cmd;
    int         need;
    if (line.len() < 2)
      return;
    cmd = line[0];
    if (cmd == "#")
      return;
    parse_fields(line);
    case (cmd)
      "W", "R", "F": need = 2;
      default:       need = 1;
    endcase
    if (fields.size() < need) begin
      n_errors++;
      $display("malformed test line: %s", line);
      return;
    end
    case (cmd)
      "B":     foreach (fields[i]) send_byte(fields[i][7:0]);
      "N":     send_noise(int'(fields[0]));
      "W":     write_word(fields[0][ADDR_WIDTH-1:0], fields[1][DATA_W-1:0]);
      "R":     read_check(fields[0][ADDR_WIDTH-1:0], fields[1][DATA_W-1:0]);
      "F":     fetch_check(fields[0][ADDR_WIDTH-1:0], fields[1][PWORD_W-1:0]);
      "T":     repeat (fields[0]) @(posedge rst);
      "S", "I": level_check(cmd, fields[0][0]);
      default: begin
        n_errors++;
        $display("unknown command in test line: %s", line);
      end
    endcase
  endtask

  initial begin
    int    fd;
    int    n_lines;
    string line;
    clk          = 1'b1;
    uart_rx      = 1'b1;  // idle line
    bus_addr     = '0;
    bus_wen      = 1'b0;
    bus_ren      = 1'b0;
    bus_wdata    = '0;
    fetch_addr   = '0;
    n_checks     = 0;
    n_errors     = 0;
    lcg_state    = 32'd96;
    limit_cycles = 0;
    n_lines      = 0;
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      n_errors++;
      $display("could not open %s", TEST_FILE);
    end else begin
      while ($fgets(line, fd) > 0)
        n_lines++;
      $fclose(fd);
      fd = $fopen(TEST_FILE, "r");
    end
    limit_cycles = 10 + (n_lines + 1) * WORST_CMD_CYC;
    repeat (10) @(posedge rst);
    #1 clk = 1'b0;
    if (fd != 0) begin
      while ($fgets(line, fd) > 0)
        run_line(line);
      $fclose(fd);
    end
    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  // watchdog
  initial begin
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge rst);
    $display("timeout: test sequence still running after %0d cycles", limit_cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/boot_tests.txt
# command letter, then hex fields: B bytes | N count | W addr data | R addr expected
# F addr expected | T cycles | S expected run | I expected irq
S 1
I 0
W 180 1234
R 180 1234
W 1FE A5C3
R 1FE A5C3
N 6
B 55 AA 00 03 00 02
S 0
B 02 AB CD 01 23 45 03 FF 00 12 34 56 78
T 10
S 1
F 000 2ABCD
F 001 12345
F 002 3FF00
R 100 1234
R 102 5678
# second image without program words
B 55 AA 00 00 00 02 9A BC DE F0
T 10
S 1
F 000 2ABCD
F 001 12345
F 002 3FF00
R 100 9ABC
R 102 DEF0
# host traffic while the loader owns the bus
B 55 AA 00 00 00 01
S 0
W 180 DEAD
W 102 BEEF
R 180 0000
B 77 88
T 10
S 1
R 100 7788
R 102 DEF0
R 180 1234
# uart receive registers
W 008 0002
B 3C
T 8
R 008 0003
I 1
R 006 003C
R 008 0002
I 0
# countdown timer
W 002 0005
W 004 0002
T 20
R 004 0003
I 1
W 004 0002
R 004 0002
I 0

//--- compile.f
common/mcu_pkg.sv
common/loader_pkg.sv
common/mem_bus_if.sv
uart/uart_rx.sv
loader/img_loader.sv
source/pmem.sv
source/dmem.sv
source/io_regs.sv
source/mcu_boot.sv
bench/mcu_boot_checker.sv
bench/tb_mcu_boot.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_mcu_boot -f compile.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_mcu_boot)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx 'TEST RESULT: PASS'; then
  exit 0
fi
exit 1
